/* command_regs.sv */
`timescale 1ns/10ps

module command_regs (
  input  logic                                         CLK,
  input  logic                                         resetn,
  input  logic                                         frame_valid,
  input  logic        [motion_pkg::OP_BITS-1:0]        frame_op,
  input  logic        [motion_pkg::DATA_BITS-1:0]      frame_data,
  output logic        [motion_pkg::DATA_BITS-1:0]      reply_word,
  output logic        [motion_pkg::MICROSTEP_BITS-1:0] microsteps,
  output logic        [motion_pkg::CURRENT_BITS-1:0]   current,
  output logic                                         enable,
  output logic                                         move_start,
  output logic        [motion_pkg::STEP_COUNT_BITS-1:0] move_count,
  output logic        [motion_pkg::PERIOD_BITS-1:0]    move_period,
  output logic                                         move_dir,
  input  logic                                         busy,
  input  logic signed [motion_pkg::ENC_BITS-1:0]       enc_count,
  input  logic                                         enc_fault
);

  logic overrun;
  logic [motion_pkg::DATA_BITS-1:0] config_word;
  logic [motion_pkg::DATA_BITS-1:0] status_word;
  logic [motion_pkg::PERIOD_BITS-1:0] period_req;
  logic [motion_pkg::STEP_COUNT_BITS-1:0] count_req;
  logic move_ok;

  assign period_req = frame_data[motion_pkg::PERIOD_BITS-1:0];
  assign count_req  = frame_data[motion_pkg::STEP_COUNT_BITS-1:0];
  assign move_ok    = frame_valid && (frame_op == motion_pkg::OP_MOVE) && !busy;

  // Readback images
  always_comb begin
    config_word = '0;
    config_word[motion_pkg::MICROSTEP_BITS-1:0] = microsteps;
    config_word[8 +: motion_pkg::CURRENT_BITS] = current;
    config_word[16] = enable;
    status_word = '0;
    status_word[0] = busy;
    status_word[1] = enc_fault;
    status_word[2] = overrun;
  end

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      microsteps  <= '0;
      current     <= '0;
      enable      <= 1'b0;
      move_period <= motion_pkg::MIN_PERIOD;
      move_start  <= 1'b0;
      overrun     <= 1'b0;
      reply_word  <= '0;
    end else begin
      move_start <= 1'b0;
      if (frame_valid) begin
        case (frame_op)
          motion_pkg::OP_CONFIG: begin
            microsteps <= frame_data[motion_pkg::MICROSTEP_BITS-1:0];
            current    <= frame_data[8 +: motion_pkg::CURRENT_BITS];
          end
          motion_pkg::OP_MOVE: begin
            if (busy)
              overrun <= 1'b1;  // Sticky until reset
            else if (count_req != '0)
              move_start <= 1'b1;
          end
          motion_pkg::OP_PERIOD: begin
            if (period_req < motion_pkg::MIN_PERIOD)
              move_period <= motion_pkg::MIN_PERIOD;
            else
              move_period <= period_req;
          end
          motion_pkg::OP_ENABLE: enable <= frame_data[0];
          default: ;
        endcase

        // Goes out during the next frame
        case (frame_op)
          motion_pkg::OP_READ_ENC:    reply_word <= enc_count;
          motion_pkg::OP_READ_STATUS: reply_word <= status_word;
          motion_pkg::OP_READ_CONFIG: reply_word <= config_word;
          default:                    reply_word <= '0;
        endcase
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (move_ok) begin
      move_count <= count_req;
      move_dir   <= frame_data[motion_pkg::DATA_BITS-1];  // 1 is reverse
    end
  end

  a_no_start_busy: assert property (@(posedge CLK) disable iff (!resetn)
    move_start |-> !busy);

endmodule

/* hbridge_phase.sv */
`timescale 1ns/10ps

module hbridge_phase (
  input  logic                                    CLK,
  input  logic                                    resetn,
  input  logic                                    step,
  input  logic                                    dir,
  input  logic                                    enable,
  input  logic [motion_pkg::MICROSTEP_BITS-1:0]   microsteps,
  input  logic [motion_pkg::CURRENT_BITS-1:0]     current,
  output logic                                    phase_a1,
  output logic                                    phase_a2,
  output logic                                    phase_b1,
  output logic                                    phase_b2,
  output logic                                    vref_a,
  output logic                                    vref_b
);

  localparam int QUAD_BITS = motion_pkg::PHASE_BITS - 2;  // Positions within a quadrant

  logic [motion_pkg::PHASE_BITS-1:0] index;
  logic [motion_pkg::PHASE_BITS-1:0] delta;
  logic [QUAD_BITS-1:0] pos;
  logic [motion_pkg::PWM_BITS-1:0] pwm_cnt;
  logic [7:0] mag_a;
  logic [7:0] mag_b;
  logic [2*motion_pkg::CURRENT_BITS-1:0] level_a;
  logic [2*motion_pkg::CURRENT_BITS-1:0] level_b;
  logic [motion_pkg::PWM_BITS-1:0] duty_a;
  logic [motion_pkg::PWM_BITS-1:0] duty_b;
  logic pos_a;
  logic pos_b;

  // |cos| in even quadrants, |sin| in odd ones
  function automatic logic [7:0] coil_mag(input logic odd_quad,
                                          input logic [QUAD_BITS-1:0] p);
    if (!odd_quad)
      return motion_pkg::PHASE_MAG[p];
    else if (p == '0)
      return 8'd0;
    else
      return motion_pkg::PHASE_MAG[QUAD_BITS'(8 - p)];
  endfunction

  assign delta = (motion_pkg::PHASE_BITS'(1) << QUAD_BITS) >> microsteps;
  assign pos   = index[QUAD_BITS-1:0];

  assign mag_a = coil_mag(index[QUAD_BITS], pos);
  assign mag_b = coil_mag(~index[QUAD_BITS], pos);  // B lags A by a quadrant

  assign pos_a = ~(index[motion_pkg::PHASE_BITS-1] ^ index[QUAD_BITS]);  // 0-7, 24-31
  assign pos_b = ~index[motion_pkg::PHASE_BITS-1];                       // 0-15

  assign level_a = current * mag_a;
  assign level_b = current * mag_b;
  assign duty_a  = level_a[2*motion_pkg::CURRENT_BITS-1 -: motion_pkg::PWM_BITS];
  assign duty_b  = level_b[2*motion_pkg::CURRENT_BITS-1 -: motion_pkg::PWM_BITS];

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      index    <= '0;
      pwm_cnt  <= '0;
      phase_a1 <= 1'b0;
      phase_a2 <= 1'b0;
      phase_b1 <= 1'b0;
      phase_b2 <= 1'b0;
      vref_a   <= 1'b0;
      vref_b   <= 1'b0;
    end else begin
      pwm_cnt <= pwm_cnt + 1'b1;
      if (enable && step)
        index <= dir ? index - delta : index + delta;  // Wraps mod 32
      phase_a1 <= enable & pos_a;
      phase_a2 <= enable & ~pos_a;
      phase_b1 <= enable & pos_b;
      phase_b2 <= enable & ~pos_b;
      vref_a   <= enable && (pwm_cnt < duty_a);
      vref_b   <= enable && (pwm_cnt < duty_b);
    end
  end

endmodule

/* motion_pkg.sv */
package motion_pkg;

  // SPI frame layout
  localparam int FRAME_BITS = 40;
  localparam int OP_BITS    = 8;
  localparam int DATA_BITS  = 32;

  localparam logic [OP_BITS-1:0] OP_CONFIG      = 8'h01;
  localparam logic [OP_BITS-1:0] OP_MOVE        = 8'h02;
  localparam logic [OP_BITS-1:0] OP_PERIOD      = 8'h03;
  localparam logic [OP_BITS-1:0] OP_ENABLE      = 8'h04;
  localparam logic [OP_BITS-1:0] OP_READ_ENC    = 8'h10;
  localparam logic [OP_BITS-1:0] OP_READ_STATUS = 8'h11;
  localparam logic [OP_BITS-1:0] OP_READ_CONFIG = 8'h12;

  localparam int STEP_COUNT_BITS = 24;
  localparam int PERIOD_BITS     = 16;
  localparam int ENC_BITS        = 32;
  localparam int MICROSTEP_BITS  = 2;
  localparam int CURRENT_BITS    = 8;
  localparam int PWM_BITS        = 8;

  // Shortest step spacing in CLK, also the reset default
  localparam logic [PERIOD_BITS-1:0] MIN_PERIOD = 16'd2;

  // 32 positions per electrical cycle
  localparam int PHASE_BITS = 5;

  // cos() over one quadrant in 8 slices, full scale 255
  localparam logic [7:0] PHASE_MAG [0:7] = '{
    8'd255, 8'd250, 8'd236, 8'd212, 8'd180, 8'd142, 8'd98, 8'd50
  };

endpackage

/* quad_enc.sv */
`timescale 1ns/10ps

module quad_enc (
  input  logic                                  CLK,
  input  logic                                  resetn,
  input  logic                                  a,
  input  logic                                  b,
  output logic signed [motion_pkg::ENC_BITS-1:0] count,
  output logic                                  fault
);

  logic [2:0] a_q;  // meta, sync, previous
  logic [2:0] b_q;
  logic a_chg;
  logic b_chg;
  logic fwd;

  assign a_chg = a_q[1] ^ a_q[2];
  assign b_chg = b_q[1] ^ b_q[2];

  // A leading B counts up
  assign fwd = a_chg ? (a_q[1] ^ b_q[1]) : ~(a_q[1] ^ b_q[1]);

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      a_q   <= 3'b000;
      b_q   <= 3'b000;
      count <= '0;
      fault <= 1'b0;
    end else begin
      a_q <= {a_q[1:0], a};
      b_q <= {b_q[1:0], b};
      if (a_chg && b_chg)
        fault <= 1'b1;  // Skipped state, count left alone
      else if (a_chg || b_chg)
        count <= fwd ? count + 1'b1 : count - 1'b1;
    end
  end

  a_fault_sticky: assert property (@(posedge CLK)
    $fell(fault) |-> !$past(resetn));

endmodule

/* rapcore.sv */
`timescale 1ns/10ps

module rapcore (
  input  logic CLK,
  input  logic resetn,
  input  logic SCK,
  input  logic CS,
  input  logic COPI,
  output logic CIPO,
  input  logic ENC_A,
  input  logic ENC_B,
  output logic PHASE_A1,
  output logic PHASE_A2,
  output logic PHASE_B1,
  output logic PHASE_B2,
  output logic VREF_A,
  output logic VREF_B,
  output logic STEPOUTPUT,
  output logic DIROUTPUT,
  output logic ENOUTPUT,
  output logic MOVE_DONE
);

  // SPI frame path
  logic frame_valid;
  logic [motion_pkg::OP_BITS-1:0] frame_op;
  logic [motion_pkg::DATA_BITS-1:0] frame_data;
  logic [motion_pkg::DATA_BITS-1:0] reply_word;

  // Motor config and move request
  logic [motion_pkg::MICROSTEP_BITS-1:0] microsteps;
  logic [motion_pkg::CURRENT_BITS-1:0] current;
  logic move_start;
  logic [motion_pkg::STEP_COUNT_BITS-1:0] move_count;
  logic [motion_pkg::PERIOD_BITS-1:0] move_period;
  logic move_dir;
  logic busy;

  logic signed [motion_pkg::ENC_BITS-1:0] enc_count;
  logic enc_fault;

  assign MOVE_DONE = ~busy;

  spi_link spi0 (
    .CLK         (CLK),
    .resetn      (resetn),
    .SCK         (SCK),
    .CS          (CS),
    .COPI        (COPI),
    .CIPO        (CIPO),
    .frame_valid (frame_valid),
    .frame_op    (frame_op),
    .frame_data  (frame_data),
    .reply_word  (reply_word)
  );

  command_regs regs0 (
    .CLK         (CLK),
    .resetn      (resetn),
    .frame_valid (frame_valid),
    .frame_op    (frame_op),
    .frame_data  (frame_data),
    .reply_word  (reply_word),
    .microsteps  (microsteps),
    .current     (current),
    .enable      (ENOUTPUT),
    .move_start  (move_start),
    .move_count  (move_count),
    .move_period (move_period),
    .move_dir    (move_dir),
    .busy        (busy),
    .enc_count   (enc_count),
    .enc_fault   (enc_fault)
  );

  step_generator stepgen0 (
    .CLK         (CLK),
    .resetn      (resetn),
    .move_start  (move_start),
    .move_count  (move_count),
    .move_period (move_period),
    .move_dir    (move_dir),
    .step        (STEPOUTPUT),
    .dir         (DIROUTPUT),
    .busy        (busy)
  );

  hbridge_phase bridge0 (
    .CLK        (CLK),
    .resetn     (resetn),
    .step       (STEPOUTPUT),
    .dir        (DIROUTPUT),  // Latched per move
    .enable     (ENOUTPUT),
    .microsteps (microsteps),
    .current    (current),
    .phase_a1   (PHASE_A1),
    .phase_a2   (PHASE_A2),
    .phase_b1   (PHASE_B1),
    .phase_b2   (PHASE_B2),
    .vref_a     (VREF_A),
    .vref_b     (VREF_B)
  );

  quad_enc encoder0 (
    .CLK    (CLK),
    .resetn (resetn),
    .a      (ENC_A),
    .b      (ENC_B),
    .count  (enc_count),
    .fault  (enc_fault)
  );

endmodule

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_rapcore -f tb.f -o tb_rapcore_sim

out=$(./obj_dir/tb_rapcore_sim 2>&1) || true
echo "$out"

if echo "$out" | grep -q "Regression passed"; then
  exit 0
fi
exit 1

/* spi_link.sv */
`timescale 1ns/10ps

module spi_link (
  input  logic                                CLK,
  input  logic                                resetn,
  input  logic                                SCK,
  input  logic                                CS,
  input  logic                                COPI,
  output logic                                CIPO,
  output logic                                frame_valid,
  output logic [motion_pkg::OP_BITS-1:0]      frame_op,
  output logic [motion_pkg::DATA_BITS-1:0]    frame_data,
  input  logic [motion_pkg::DATA_BITS-1:0]    reply_word
);

  localparam int CNT_BITS = $clog2(motion_pkg::FRAME_BITS + 2);
  localparam logic [CNT_BITS-1:0] FULL = CNT_BITS'(motion_pkg::FRAME_BITS);
  localparam logic [CNT_BITS-1:0] REPLY_FIRST = CNT_BITS'(motion_pkg::OP_BITS);

  logic [2:0] sck_q;  // meta, sync, previous
  logic [2:0] cs_q;
  logic [1:0] copi_q;
  logic sck_rise;
  logic sck_fall;
  logic cs_rise;
  logic cs_active;
  logic tx_shift;
  logic load_reply;
  logic [CNT_BITS-1:0] bit_cnt;
  logic [motion_pkg::FRAME_BITS-1:0] rx_sr;
  logic [motion_pkg::DATA_BITS-1:0] tx_sr;

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      sck_q  <= 3'b000;
      cs_q   <= 3'b111;  // Bus idle
      copi_q <= 2'b00;
    end else begin
      sck_q  <= {sck_q[1:0], SCK};
      cs_q   <= {cs_q[1:0], CS};
      copi_q <= {copi_q[0], COPI};
    end
  end

  assign sck_rise  = sck_q[1] & ~sck_q[2];
  assign sck_fall  = ~sck_q[1] & sck_q[2];
  assign cs_rise   = cs_q[1] & ~cs_q[2];
  assign cs_active = ~cs_q[1];

  // Reply bits go out after the opcode byte
  assign tx_shift = cs_active && sck_fall && (bit_cnt >= REPLY_FIRST) && (bit_cnt < FULL);

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      bit_cnt     <= '0;
      frame_valid <= 1'b0;
      load_reply  <= 1'b0;
    end else begin
      frame_valid <= cs_rise && (bit_cnt == FULL);  // Short or long frames dropped
      load_reply  <= frame_valid;
      if (!cs_active)
        bit_cnt <= '0;
      else if (sck_rise && bit_cnt <= FULL)
        bit_cnt <= bit_cnt + 1'b1;  // Saturates one past a full frame
    end
  end

  always_ff @(posedge CLK) begin
    if (cs_active && sck_rise)
      rx_sr <= {rx_sr[motion_pkg::FRAME_BITS-2:0], copi_q[1]};
    if (cs_rise) begin
      frame_op   <= rx_sr[motion_pkg::FRAME_BITS-1 -: motion_pkg::OP_BITS];
      frame_data <= rx_sr[motion_pkg::DATA_BITS-1:0];
    end
  end

  // Reply waits one cycle for command_regs to register it
  always_ff @(posedge CLK) begin
    if (load_reply)
      tx_sr <= reply_word;
    else if (tx_shift)
      tx_sr <= {tx_sr[motion_pkg::DATA_BITS-2:0], 1'b0};
  end

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      CIPO <= 1'b0;
    end else if (!cs_active) begin
      CIPO <= 1'b0;
    end else if (sck_fall) begin
      CIPO <= tx_shift ? tx_sr[motion_pkg::DATA_BITS-1] : 1'b0;
    end
  end

  a_valid_cs_idle: assert property (@(posedge CLK) disable iff (!resetn)
    $rose(frame_valid) |-> cs_q[1]);

endmodule

/* step_generator.sv */
`timescale 1ns/10ps

module step_generator (
  input  logic                                     CLK,
  input  logic                                     resetn,
  input  logic                                     move_start,
  input  logic [motion_pkg::STEP_COUNT_BITS-1:0]   move_count,
  input  logic [motion_pkg::PERIOD_BITS-1:0]       move_period,
  input  logic                                     move_dir,
  output logic                                     step,
  output logic                                     dir,
  output logic                                     busy
);

  logic [motion_pkg::STEP_COUNT_BITS-1:0] remaining;
  logic [motion_pkg::PERIOD_BITS-1:0] period_q;
  logic [motion_pkg::PERIOD_BITS-1:0] timer;
  logic start_ok;

  assign start_ok = move_start && !busy && (move_count != '0);

  always_ff @(posedge CLK) begin
    if (start_ok)
      period_q <= move_period;
  end

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      busy      <= 1'b0;
      step      <= 1'b0;
      dir       <= 1'b0;
      remaining <= '0;
      timer     <= '0;
    end else begin
      step <= 1'b0;
      if (!busy) begin
        if (start_ok) begin
          busy      <= 1'b1;
          dir       <= move_dir;  // Held for the whole move
          remaining <= move_count;
          timer     <= move_period - 1'b1;
        end
      end else if (remaining == '0) begin
        busy <= 1'b0;  // Last pulse went out last cycle
      end else if (timer == '0) begin
        step      <= 1'b1;
        remaining <= remaining - 1'b1;
        timer     <= period_q - 1'b1;
      end else begin
        timer <= timer - 1'b1;
      end
    end
  end

  a_step_single: assert property (@(posedge CLK) disable iff (!resetn)
    step |=> !step);

endmodule

/* tb.f */
motion_pkg.sv
spi_link.sv
command_regs.sv
step_generator.sv
hbridge_phase.sv
quad_enc.sv
rapcore.sv
tb_rapcore.sv

/* tb_rapcore.sv */
`timescale 1ns/10ps

module tb_rapcore;

  logic CLK = 1'b0;
  logic resetn;
  logic SCK;
  logic CS;
  logic COPI;
  logic CIPO;
  logic ENC_A;
  logic ENC_B;
  logic PHASE_A1;
  logic PHASE_A2;
  logic PHASE_B1;
  logic PHASE_B2;
  logic VREF_A;
  logic VREF_B;
  logic STEPOUTPUT;
  logic DIROUTPUT;
  logic ENOUTPUT;
  logic MOVE_DONE;

  // Expectations set by the stimulus, read by the monitors
  logic exp_dir = 1'b0;
  int exp_period = 2;
  logic [1:0] model_ms = 2'd0;
  logic [1:0] gray_pos = 2'd0;

  // Pulse monitor state
  int pulse_total = 0;
  int gap = 1000;
  logic [4:0] model_idx = 5'd0;
  logic [1:0] phase_due = 2'b00;

  rapcore rapcore_inst (
    .CLK        (CLK),
    .resetn     (resetn),
    .SCK        (SCK),
    .CS         (CS),
    .COPI       (COPI),
    .CIPO       (CIPO),
    .ENC_A      (ENC_A),
    .ENC_B      (ENC_B),
    .PHASE_A1   (PHASE_A1),
    .PHASE_A2   (PHASE_A2),
    .PHASE_B1   (PHASE_B1),
    .PHASE_B2   (PHASE_B2),
    .VREF_A     (VREF_A),
    .VREF_B     (VREF_B),
    .STEPOUTPUT (STEPOUTPUT),
    .DIROUTPUT  (DIROUTPUT),
    .ENOUTPUT   (ENOUTPUT),
    .MOVE_DONE  (MOVE_DONE)
  );

  always #10 CLK = ~CLK;

  task automatic fail_now(input string line);
    $display("%s", line);
    $display("Regression failed");
    $fatal(1, "Stopping at first failure");
  endtask

  task automatic value_error(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    fail_now($sformatf("Error at %0t ns: %s expected 0x%0h, got 0x%0h",
                       $time, name, expected, actual));
  endtask

  // Coil polarity {a1, a2, b1, b2} for a phase index
  function automatic logic [3:0] expected_poles(input logic [4:0] idx);
    logic a_fwd;
    logic b_fwd;
    a_fwd = (idx < 5'd8) || (idx >= 5'd24);
    b_fwd = idx < 5'd16;
    return {a_fwd, !a_fwd, b_fwd, !b_fwd};
  endfunction

  // 8 CLK per bit, host samples CIPO just before each rising SCK
  task automatic spi_frame(input logic [7:0] op, input logic [31:0] data,
                           output logic [31:0] reply);
    logic [39:0] frame;
    frame = {op, data};
    reply = '0;
    CS = 1'b0;
    for (int i = 39; i >= 0; i--) begin
      COPI = frame[i];
      repeat (4) @(posedge CLK);
      #2;
      if (i < 32)
        reply = {reply[30:0], CIPO};
      SCK = 1'b1;
      repeat (4) @(posedge CLK);
      #2;
      SCK = 1'b0;
    end
    repeat (4) @(posedge CLK);
    #2;
    CS = 1'b1;
    repeat (10) @(posedge CLK);  // Frame decoded and reply loaded
    #2;
  endtask

  task automatic read_reg(input logic [7:0] op, output logic [31:0] value);
    logic [31:0] unused;
    spi_frame(op, 32'd0, unused);
    spi_frame(8'h00, 32'd0, value);  // Unknown opcode as a dummy
  endtask

  task automatic wait_move_done(input int limit);
    int n;
    n = 0;
    while (!MOVE_DONE) begin
      @(posedge CLK);
      #2;
      n++;
      if (n > limit)
        fail_now("Move did not finish within the expected number of cycles");
    end
  endtask

  task automatic run_move(input int count, input logic dir);
    int start_total;
    logic [31:0] reply;
    start_total = pulse_total;
    exp_dir = dir;
    spi_frame(motion_pkg::OP_MOVE, {dir, 7'd0, 24'(count)}, reply);
    wait_move_done(count * 25 + 100);
    assert (pulse_total - start_total == count)
      else value_error("STEPOUTPUT pulse count", 32'(count), 32'(pulse_total - start_total));
  endtask

  task automatic move_encoder(input logic up);
    gray_pos = up ? gray_pos + 2'd1 : gray_pos - 2'd1;
    ENC_A = gray_pos[1] ^ gray_pos[0];
    ENC_B = gray_pos[1];
    repeat (5) @(posedge CLK);
    #2;
  endtask

  // Step spacing, pulse count and phase model
  always @(negedge CLK) begin
    if (resetn) begin
      gap = gap + 1;
      if (phase_due[1] && ENOUTPUT) begin
        assert ({PHASE_A1, PHASE_A2, PHASE_B1, PHASE_B2} == expected_poles(model_idx))
          else value_error("PHASE_A1/A2/B1/B2", 32'(expected_poles(model_idx)),
                           32'({PHASE_A1, PHASE_A2, PHASE_B1, PHASE_B2}));
      end
      phase_due = {phase_due[0], STEPOUTPUT};
      if (STEPOUTPUT) begin
        assert (gap >= exp_period)
          else value_error("STEPOUTPUT spacing", 32'(exp_period), 32'(gap));
        gap = 0;
        pulse_total = pulse_total + 1;
        if (ENOUTPUT)
          model_idx = exp_dir ? model_idx - (5'd8 >> model_ms)
                              : model_idx + (5'd8 >> model_ms);
      end
    end
  end

  a_dir_at_step: assert property (@(posedge CLK) disable iff (!resetn)
    STEPOUTPUT |-> DIROUTPUT == exp_dir)
    else value_error("DIROUTPUT", 32'(exp_dir), 32'(DIROUTPUT));

  a_busy_at_step: assert property (@(posedge CLK) disable iff (!resetn)
    STEPOUTPUT |-> !MOVE_DONE)
    else value_error("MOVE_DONE", 32'd0, 32'(MOVE_DONE));

  a_off_when_disabled: assert property (@(posedge CLK) disable iff (!resetn)
    !ENOUTPUT |=> {PHASE_A1, PHASE_A2, PHASE_B1, PHASE_B2, VREF_A, VREF_B} == 6'd0)
    else value_error("PHASE/VREF outputs", 32'd0,
                     32'({PHASE_A1, PHASE_A2, PHASE_B1, PHASE_B2, VREF_A, VREF_B}));

  // About 20k cycles of work, so 2 ms leaves a wide margin
  initial begin
    #2_000_000;
    fail_now("Timeout: the run did not finish within 2 ms");
  end

  initial begin
    logic [31:0] reply;
    logic [31:0] cfg_exp;
    logic mdir;
    int cur;
    int count;
    int fwd_n;
    int rev_n;
    void'($urandom(81));
    resetn = 1'b0;
    SCK = 1'b0;
    CS = 1'b1;
    COPI = 1'b0;
    ENC_A = 1'b0;
    ENC_B = 1'b0;
    repeat (4) @(posedge CLK);
    #2;
    resetn = 1'b1;

    // Reset state
    assert (MOVE_DONE == 1'b1) else value_error("MOVE_DONE", 32'd1, 32'(MOVE_DONE));
    assert ({STEPOUTPUT, ENOUTPUT, CIPO} == 3'd0)
      else value_error("STEPOUTPUT/ENOUTPUT/CIPO", 32'd0, 32'({STEPOUTPUT, ENOUTPUT, CIPO}));
    assert ({PHASE_A1, PHASE_A2, PHASE_B1, PHASE_B2, VREF_A, VREF_B} == 6'd0)
      else value_error("PHASE/VREF outputs", 32'd0,
                       32'({PHASE_A1, PHASE_A2, PHASE_B1, PHASE_B2, VREF_A, VREF_B}));
    read_reg(motion_pkg::OP_READ_STATUS, reply);
    assert (reply == 32'd0) else value_error("status", 32'd0, reply);
    read_reg(motion_pkg::OP_READ_ENC, reply);
    assert (reply == 32'd0) else value_error("encoder count", 32'd0, reply);

    // Configuration readback
    model_ms = 2'($urandom_range(0, 3));
    cur = $urandom_range(0, 255);
    spi_frame(motion_pkg::OP_CONFIG, {16'd0, 8'(cur), 6'd0, model_ms}, reply);
    spi_frame(motion_pkg::OP_ENABLE, 32'd1, reply);
    cfg_exp = 32'(model_ms) | (32'(cur) << 8) | (32'd1 << 16);
    read_reg(motion_pkg::OP_READ_CONFIG, reply);
    assert (reply == cfg_exp) else value_error("config readback", cfg_exp, reply);
    assert (ENOUTPUT == 1'b1) else value_error("ENOUTPUT", 32'd1, 32'(ENOUTPUT));

    // Period 0 is clamped to 2
    exp_period = 2;
    spi_frame(motion_pkg::OP_PERIOD, 32'd0, reply);
    run_move($urandom_range(1, 40), 1'($urandom_range(0, 1)));

    model_ms = 2'($urandom_range(0, 3));
    spi_frame(motion_pkg::OP_CONFIG, {16'd0, 8'(cur), 6'd0, model_ms}, reply);
    exp_period = $urandom_range(2, 20);
    spi_frame(motion_pkg::OP_PERIOD, 32'(exp_period), reply);
    run_move($urandom_range(1, 40), 1'($urandom_range(0, 1)));

    // Driver off, index must hold
    spi_frame(motion_pkg::OP_ENABLE, 32'd0, reply);
    exp_period = $urandom_range(2, 20);
    spi_frame(motion_pkg::OP_PERIOD, 32'(exp_period), reply);
    run_move($urandom_range(1, 40), 1'($urandom_range(0, 1)));
    spi_frame(motion_pkg::OP_ENABLE, 32'd1, reply);

    // Long move so two more frames land while busy
    exp_period = 20;
    spi_frame(motion_pkg::OP_PERIOD, 32'd20, reply);
    count = $urandom_range(36, 40);
    mdir = 1'($urandom_range(0, 1));
    exp_dir = mdir;
    fwd_n = pulse_total;
    spi_frame(motion_pkg::OP_MOVE, {mdir, 7'd0, 24'(count)}, reply);
    spi_frame(motion_pkg::OP_READ_STATUS, 32'd0, reply);
    spi_frame(motion_pkg::OP_MOVE, {~mdir, 7'd0, 24'd5}, reply);  // Rejected
    assert (reply == 32'h1) else value_error("status during move", 32'h1, reply);
    wait_move_done(count * 25 + 100);
    assert (pulse_total - fwd_n == count)
      else value_error("STEPOUTPUT pulse count", 32'(count), 32'(pulse_total - fwd_n));
    read_reg(motion_pkg::OP_READ_STATUS, reply);
    assert (reply == 32'h4) else value_error("status overrun", 32'h4, reply);

    // Encoder
    fwd_n = $urandom_range(1, 30);
    rev_n = $urandom_range(1, 30);
    for (int i = 0; i < fwd_n; i++)
      move_encoder(1'b1);
    for (int i = 0; i < rev_n; i++)
      move_encoder(1'b0);
    read_reg(motion_pkg::OP_READ_ENC, reply);
    assert (reply == 32'(fwd_n - rev_n))
      else value_error("encoder count", 32'(fwd_n - rev_n), reply);
    ENC_A = ~ENC_A;
    ENC_B = ~ENC_B;
    repeat (5) @(posedge CLK);
    #2;
    read_reg(motion_pkg::OP_READ_STATUS, reply);
    assert (reply == 32'h6) else value_error("status fault", 32'h6, reply);
    read_reg(motion_pkg::OP_READ_ENC, reply);
    assert (reply == 32'(fwd_n - rev_n))
      else value_error("encoder count after fault", 32'(fwd_n - rev_n), reply);

    $display("Regression passed");
    $finish;
  end

endmodule
